// ==== verilog/pci_target_pkg.sv ====
`default_nettype none

package pci_target_pkg;

	////////////////////////////////////////////////////////////
	// Bus and memory widths
	////////////////////////////////////////////////////////////

	typedef logic [31:0] addr_t;                   // PCI byte address
	typedef logic [31:0] data_t;                   // One data word on ad
	typedef logic [3:0]  cbe_t;                    // Command in address phase, byte enables after
	typedef logic [5:0]  word_idx_t;               // Word index into the target RAM

	////////////////////////////////////////////////////////////
	// Memory window and burst limits
	////////////////////////////////////////////////////////////

	localparam int    MEM_WORDS  = 64;             // RAM depth, window is 256 bytes
	localparam addr_t MEM_BASE   = 32'h0000_1000;  // First byte of the window
	localparam int    LINE_WORDS = 4;              // Cache line, read-line length and wrap span
	localparam int    READ_WORDS = 2;              // Most words a plain memory read may take

	////////////////////////////////////////////////////////////
	// Command codes and burst order
	////////////////////////////////////////////////////////////

	localparam cbe_t CMD_MEM_READ      = 4'b0110;  // Memory read
	localparam cbe_t CMD_MEM_WRITE     = 4'b0111;  // Memory write
	localparam cbe_t CMD_MEM_READ_MULT = 4'b1100;  // Memory read multiple
	localparam cbe_t CMD_MEM_READ_LINE = 4'b1110;  // Memory read line

	// Burst order sits in ad[1:0] of the address phase
	localparam logic [1:0] BURST_LINEAR = 2'b00;   // Incrementing
	localparam logic [1:0] BURST_WRAP   = 2'b10;   // Cache line wrap

	////////////////////////////////////////////////////////////
	// Target FSM states
	////////////////////////////////////////////////////////////

	typedef enum logic [2:0]
	{
		st_idle,                                   // Bus free, waiting for frame
		st_decode,                                 // Address latched, checking the hit
		st_turnaround,                             // Read turnaround, devsel low, ad not driven
		st_write,                                  // Write data phases
		st_read,                                   // Read data phases, ad driven
		st_stop,                                   // Disconnect, waiting for frame high
		st_terminate                               // All control high for one cycle
	} target_state_e;

	////////////////////////////////////////////////////////////
	// RAM request from the FSM
	////////////////////////////////////////////////////////////

	typedef struct packed
	{
		logic      we;                             // Write strobe for this edge
		logic [3:0] be;                            // Byte enables, active high
		word_idx_t idx;                            // Word being read or written
		data_t     wdata;                          // Write data from ad
	} ram_req_t;

endpackage

`default_nettype wire

// ==== verilog/target_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module target_ram
(
	input  wire logic                      clk,
	input  wire pci_target_pkg::ram_req_t  req,
	output pci_target_pkg::data_t          rdata
);

	////////////////////////////////////////////////////////////
	// Storage
	////////////////////////////////////////////////////////////

	pci_target_pkg::data_t mem [pci_target_pkg::MEM_WORDS];  // Window contents

	// Byte lanes written on the edge of a completed write phase
	always_ff @(posedge clk)
	begin
		if (req.we)                                            // Only on a completed phase
		begin
			for (int b = 0; b < $bits(req.be); b++)
			begin
				if (req.be[b])                                 // Lane enabled by the master
				begin
					mem[req.idx][b*8 +: 8] <= req.wdata[b*8 +: 8];
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Read port
	////////////////////////////////////////////////////////////

	assign rdata = mem[req.idx];                               // Asynchronous read of current word

endmodule

`default_nettype wire

// ==== verilog/burst_addr_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module burst_addr_gen
(
	input  wire logic                      clk,
	input  wire logic                      rst,
	input  wire logic                      load,
	input  wire logic                      advance,
	input  wire pci_target_pkg::addr_t     start_addr,
	input  wire pci_target_pkg::cbe_t      cmd,
	output logic                           hit,
	output logic                           last_word,
	output logic                           budget_out,
	output pci_target_pkg::word_idx_t      idx
);

	pci_target_pkg::addr_t     offset;       // Byte offset from the window base
	logic                      in_window;    // Start address inside the window
	logic                      order_ok;     // Linear or wrap, reserved orders miss
	logic                      wrap_q;       // Latched burst order
	logic [2:0]                budget_q;     // Words left, zero when unlimited
	logic [2:0]                budget_init;  // Budget for the command in the address phase
	pci_target_pkg::word_idx_t line_mask;    // Index bits inside one cache line
	pci_target_pkg::word_idx_t idx_next;     // Index of the following word

	////////////////////////////////////////////////////////////
	// Address phase decode
	////////////////////////////////////////////////////////////

	assign offset    = start_addr - pci_target_pkg::MEM_BASE;
	assign in_window = offset < pci_target_pkg::addr_t'(pci_target_pkg::MEM_WORDS * 4);
	assign order_ok  = (start_addr[1:0] == pci_target_pkg::BURST_LINEAR) ||
	                   (start_addr[1:0] == pci_target_pkg::BURST_WRAP);

	always_comb
	begin
		case (cmd)
			pci_target_pkg::CMD_MEM_READ      : budget_init = 3'(pci_target_pkg::READ_WORDS);
			pci_target_pkg::CMD_MEM_READ_LINE : budget_init = 3'(pci_target_pkg::LINE_WORDS);
			default                           : budget_init = 3'd0;  // Frame ends the burst
		endcase
	end

	////////////////////////////////////////////////////////////
	// Next word
	////////////////////////////////////////////////////////////

	assign line_mask = pci_target_pkg::word_idx_t'(pci_target_pkg::LINE_WORDS - 1);

	always_comb
	begin
		if (wrap_q)
			idx_next = (idx & ~line_mask) | ((idx + 1'b1) & line_mask);  // Stay inside the line
		else
			idx_next = idx + 1'b1;                                   // Plain increment
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			hit      <= 1'b0;
			wrap_q   <= 1'b0;
			idx      <= '0;
			budget_q <= 3'd0;
		end
		else if (load)                                           // Address phase
		begin
			hit      <= in_window && order_ok;
			wrap_q   <= (start_addr[1:0] == pci_target_pkg::BURST_WRAP);
			idx      <= offset[2 +: $bits(pci_target_pkg::word_idx_t)];
			budget_q <= budget_init;
		end
		else if (advance)                                        // One completed data phase
		begin
			idx <= idx_next;
			if (budget_q > 3'd1)
				budget_q <= budget_q - 3'd1;                     // Holds at one once spent
		end
	end

	// Window end only matters for linear bursts, wrap never leaves its line
	assign last_word  = !wrap_q && (idx == pci_target_pkg::word_idx_t'(pci_target_pkg::MEM_WORDS - 1));
	assign budget_out = (budget_q == 3'd1);                      // Current word is the last allowed

endmodule

`default_nettype wire

// ==== verilog/target_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module target_fsm
(
	input  wire logic                       clk,
	input  wire logic                       rst,
	input  wire logic                       frame,
	input  wire logic                       irdy,
	input  wire pci_target_pkg::addr_t      ad_in,
	input  wire pci_target_pkg::cbe_t       cbe_in,
	input  wire logic                       hit,
	input  wire logic                       last_word,
	input  wire logic                       budget_out,
	input  wire pci_target_pkg::word_idx_t  idx,
	input  wire pci_target_pkg::data_t      rdata,
	output logic                            load,
	output logic                            advance,
	output pci_target_pkg::ram_req_t        ram_req,
	output logic                            devsel,
	output logic                            trdy,
	output logic                            stop,
	output pci_target_pkg::data_t           ad_out,
	output logic                            ad_oe
);

	pci_target_pkg::target_state_e state;       // Bus FSM state
	pci_target_pkg::target_state_e state_nxt;   // Next state
	pci_target_pkg::cbe_t          cmd_q;       // Command from the address phase
	logic                          rd_valid;    // ad_out holds the word at idx
	logic                          is_write;    // Latched command is a memory write
	logic                          is_read;     // Latched command is one of the reads
	logic                          claim;       // Take the transaction
	logic                          data_rdy;    // Target ready, trdy active high
	logic                          phase_done;  // irdy and trdy both low on this edge
	logic                          final_word;  // Current word is the last one allowed
	logic                          rd_fill;     // Load ad_out from the RAM on this edge

	////////////////////////////////////////////////////////////
	// Decode of the latched command
	////////////////////////////////////////////////////////////

	assign is_write = (cmd_q == pci_target_pkg::CMD_MEM_WRITE);
	assign is_read  = (cmd_q == pci_target_pkg::CMD_MEM_READ)      ||
	                  (cmd_q == pci_target_pkg::CMD_MEM_READ_MULT) ||
	                  (cmd_q == pci_target_pkg::CMD_MEM_READ_LINE);
	assign claim    = hit && (is_write || is_read);      // Unsupported commands never see devsel

	////////////////////////////////////////////////////////////
	// Data phase handshake
	////////////////////////////////////////////////////////////

	// Reads get one wait cycle after each word so ad_out can be reloaded from the new idx
	assign data_rdy   = (state == pci_target_pkg::st_write) ||
	                    ((state == pci_target_pkg::st_read) && rd_valid);
	assign phase_done = data_rdy && !irdy;
	assign final_word = last_word || budget_out;        // Window end or read budget spent
	assign rd_fill    = (state == pci_target_pkg::st_turnaround) ||
	                    ((state == pci_target_pkg::st_read) && !rd_valid);

	assign load    = (state == pci_target_pkg::st_idle) && !frame;  // Address phase
	assign advance = phase_done;                                    // Step idx after each word

	// Write request, byte enables flipped to active high
	always_comb
	begin
		ram_req.we    = phase_done && (state == pci_target_pkg::st_write);
		ram_req.be    = ~cbe_in;
		ram_req.idx   = idx;
		ram_req.wdata = pci_target_pkg::data_t'(ad_in);
	end

	////////////////////////////////////////////////////////////
	// Next state
	////////////////////////////////////////////////////////////

	always_comb
	begin
		state_nxt = state;                                       // Hold by default
		case (state)
			pci_target_pkg::st_idle :
				if (!frame)
					state_nxt = pci_target_pkg::st_decode;       // Master starts a transaction
			pci_target_pkg::st_decode :
				if (claim)
					state_nxt = is_write ? pci_target_pkg::st_write
					                     : pci_target_pkg::st_turnaround;
				else if (frame)
					state_nxt = pci_target_pkg::st_idle;         // Not ours, bus went idle
			pci_target_pkg::st_turnaround :
				state_nxt = pci_target_pkg::st_read;             // First word loaded on this edge
			pci_target_pkg::st_write,
			pci_target_pkg::st_read :
				if (phase_done)
				begin
					if (frame)
						state_nxt = pci_target_pkg::st_terminate; // Master's last word
					else if (final_word)
						state_nxt = pci_target_pkg::st_stop;      // Disconnect with data
				end
			pci_target_pkg::st_stop :
				if (frame)
					state_nxt = pci_target_pkg::st_terminate;    // Master saw stop
			pci_target_pkg::st_terminate :
				state_nxt = pci_target_pkg::st_idle;
			default :
				state_nxt = pci_target_pkg::st_idle;
		endcase
	end

	////////////////////////////////////////////////////////////
	// State and control registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			state    <= pci_target_pkg::st_idle;
			cmd_q    <= '0;                                      // No valid command
			rd_valid <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			if (load)
				cmd_q <= cbe_in;                                 // Command rides on c_be in address phase
			if (rd_fill)
				rd_valid <= 1'b1;
			else if (phase_done)
				rd_valid <= 1'b0;                                // Word taken, fetch the next one
		end
	end

	// Read data register
	always_ff @(posedge clk)
	begin
		if (rd_fill)
			ad_out <= rdata;
	end

	////////////////////////////////////////////////////////////
	// PCI control outputs, active low
	////////////////////////////////////////////////////////////

	assign devsel = !((state == pci_target_pkg::st_turnaround) ||
	                  (state == pci_target_pkg::st_write)      ||
	                  (state == pci_target_pkg::st_read)       ||
	                  (state == pci_target_pkg::st_stop));
	assign trdy   = !data_rdy;
	assign stop   = !((state == pci_target_pkg::st_stop) || (data_rdy && final_word));
	assign ad_oe  = (state == pci_target_pkg::st_read);     // Drive ad only after turnaround

endmodule

`default_nettype wire

// ==== verilog/pci_target_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pci_target_top
(
	input  wire logic                   clk,
	input  wire logic                   rst,
	input  wire logic                   frame,
	input  wire logic                   irdy,
	input  wire pci_target_pkg::addr_t  ad_in,
	input  wire pci_target_pkg::cbe_t   cbe_in,
	output logic                        devsel,
	output logic                        trdy,
	output logic                        stop,
	output pci_target_pkg::data_t       ad_out,
	output logic                        ad_oe
);

	logic                      load;        // Address phase strobe
	logic                      advance;     // Completed data phase
	logic                      hit;         // Start address decodes to the window
	logic                      last_word;   // Window end reached
	logic                      budget_out;  // Read budget spent
	pci_target_pkg::word_idx_t idx;         // Current word
	pci_target_pkg::data_t     rdata;       // RAM read data
	pci_target_pkg::ram_req_t  ram_req;     // FSM to RAM

	////////////////////////////////////////////////////////////
	// Bus FSM
	////////////////////////////////////////////////////////////

	target_fsm u_fsm
	(
		.clk        (clk),
		.rst        (rst),
		.frame      (frame),
		.irdy       (irdy),
		.ad_in      (ad_in),
		.cbe_in     (cbe_in),
		.hit        (hit),
		.last_word  (last_word),
		.budget_out (budget_out),
		.idx        (idx),
		.rdata      (rdata),
		.load       (load),
		.advance    (advance),
		.ram_req    (ram_req),
		.devsel     (devsel),
		.trdy       (trdy),
		.stop       (stop),
		.ad_out     (ad_out),
		.ad_oe      (ad_oe)
	);

	// Decode and burst counter, address and command taken straight off the pins
	burst_addr_gen u_addr
	(
		.clk        (clk),
		.rst        (rst),
		.load       (load),
		.advance    (advance),
		.start_addr (ad_in),
		.cmd        (cbe_in),
		.hit        (hit),
		.last_word  (last_word),
		.budget_out (budget_out),
		.idx        (idx)
	);

	target_ram u_ram
	(
		.clk   (clk),
		.req   (ram_req),
		.rdata (rdata)
	);

endmodule

`default_nettype wire

// ==== test/pci_target_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module pci_target_props
(
	input wire logic                          clk,
	input wire logic                          rst,
	input wire logic                          frame,
	input wire logic                          irdy,
	input wire logic                          is_read,
	input wire logic                          devsel,
	input wire logic                          trdy,
	input wire logic                          stop,
	input wire logic                          ad_oe
);

	////////////////////////////////////////////////////////////
	// Bus protocol rules on the target side
	////////////////////////////////////////////////////////////

	a_trdy_devsel : assert property (@(posedge clk) disable iff (!rst)
		!trdy |-> !devsel)
		else $error("trdy low while devsel is high");

	// ad driven only for a latched read command and never in the claim cycle
	a_oe_read : assert property (@(posedge clk) disable iff (!rst)
		ad_oe |-> (is_read && $past(!devsel)))                  // Turnaround comes first
		else $error("ad_oe high outside a read data phase");

	// Reset leaves every control output released
	a_reset_idle : assert property (@(posedge clk)
		!rst |=> (devsel && trdy && stop && !ad_oe))
		else $error("control outputs active after reset");

	// Bus idle means frame and irdy both high
	a_idle_stop : assert property (@(posedge clk) disable iff (!rst)
		(frame && irdy && $past(frame && irdy)) |-> stop)
		else $error("stop low on an idle bus");

endmodule

bind target_fsm pci_target_props u_props
(
	.clk     (clk),
	.rst     (rst),
	.frame   (frame),
	.irdy    (irdy),
	.is_read (is_read),
	.devsel  (devsel),
	.trdy    (trdy),
	.stop    (stop),
	.ad_oe   (ad_oe)
);

`default_nettype wire

// ==== test/pci_target_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pci_target_tb;

	typedef pci_target_pkg::addr_t     addr_t;
	typedef pci_target_pkg::data_t     data_t;
	typedef pci_target_pkg::cbe_t      cbe_t;
	typedef pci_target_pkg::word_idx_t word_idx_t;

	localparam cbe_t       WR   = pci_target_pkg::CMD_MEM_WRITE;
	localparam cbe_t       RD   = pci_target_pkg::CMD_MEM_READ;
	localparam cbe_t       RM   = pci_target_pkg::CMD_MEM_READ_MULT;
	localparam cbe_t       RL   = pci_target_pkg::CMD_MEM_READ_LINE;
	localparam logic [1:0] LIN  = pci_target_pkg::BURST_LINEAR;
	localparam logic [1:0] WRAP = pci_target_pkg::BURST_WRAP;
	localparam addr_t      BASE = pci_target_pkg::MEM_BASE;

	localparam int NUM_ROWS       = 20;
	localparam int MAX_PHASES     = 64;
	localparam int TIMEOUT_CYCLES = 40 + NUM_ROWS * (MAX_PHASES * 6 + 24);

	// One bus transaction as the master sees it
	typedef struct packed
	{
		cbe_t       cmd;     // Command in the address phase
		addr_t      addr;    // Start address, burst order in bits 1:0
		logic [7:0] phases;  // Data phases the master asks for
		cbe_t       be;      // Byte enables, active low
		data_t      seed;    // Base of the write data
		logic       fill;    // Write data from the address fill pattern
	} row_t;

	logic  clk;
	logic  rst;
	logic  frame;
	logic  irdy;
	addr_t ad_in;
	cbe_t  cbe_in;
	logic  devsel;
	logic  trdy;
	logic  stop;
	data_t ad_out;
	logic  ad_oe;

	row_t   rows [NUM_ROWS];                 // Stimulus table
	data_t  ref_mem [pci_target_pkg::MEM_WORDS];  // Expected RAM contents
	int     errors;
	int     checks;
	int     cycles;
	integer seed;

	pci_target_top dut0
	(
		.clk    (clk),
		.rst    (rst),
		.frame  (frame),
		.irdy   (irdy),
		.ad_in  (ad_in),
		.cbe_in (cbe_in),
		.devsel (devsel),
		.trdy   (trdy),
		.stop   (stop),
		.ad_out (ad_out),
		.ad_oe  (ad_oe)
	);

	always #4 clk = ~clk;                    // 8 ns period

	// Hard stop if the bus master gets stuck
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TEST RESULT: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	task automatic check(input string what, input data_t got, input data_t exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	function automatic addr_t waddr(input int w, input logic [1:0] order);
		waddr = BASE + (addr_t'(w) << 2) + addr_t'(order);  // Word address plus burst order
	endfunction

	function automatic data_t fill_word(input addr_t a);
		fill_word = (a * 32'h9E37_79B9) ^ {a[15:0], a[31:16]};  // Every address bit counts
	endfunction

	function automatic word_idx_t word_at(input row_t row, input int k);
		addr_t     off;
		word_idx_t w0;
		word_idx_t step;
		off  = row.addr - BASE;
		w0   = off[7:2];
		step = word_idx_t'(k);
		if (row.addr[1:0] == WRAP)
			word_at = {w0[5:2], 2'(w0[1:0] + step[1:0])};  // Wraps inside the 4-word line
		else
			word_at = w0 + step;
	endfunction

	function automatic logic claims(input row_t row);
		logic supported;
		supported = (row.cmd == WR) || (row.cmd == RD) || (row.cmd == RM) || (row.cmd == RL);
		claims = supported && (row.addr >= BASE) &&
		         (row.addr < BASE + addr_t'(pci_target_pkg::MEM_WORDS * 4)) &&
		         ((row.addr[1:0] == LIN) || (row.addr[1:0] == WRAP));
	endfunction

	// Transfer k is the last one the target allows
	function automatic logic stop_at(input row_t row, input int k);
		word_idx_t w;
		w = word_at(row, k);
		stop_at = ((row.addr[1:0] != WRAP) &&
		           (w == word_idx_t'(pci_target_pkg::MEM_WORDS - 1))) ||
		          ((row.cmd == RD) && (k == pci_target_pkg::READ_WORDS - 1)) ||
		          ((row.cmd == RL) && (k == pci_target_pkg::LINE_WORDS - 1));
	endfunction

	function automatic data_t write_data(input row_t row, input int k, input word_idx_t w);
		if (row.fill)
			write_data = fill_word(BASE + (addr_t'(w) << 2));
		else
			write_data = row.seed + data_t'(k) * 32'h0101_0103;
	endfunction

	////////////////////////////////////////////////////////////
	// Bus master
	////////////////////////////////////////////////////////////

	task automatic run_row(input row_t row);
		int        k;             // Completed transfers
		int        t;             // Cycles since the address phase edge
		int        n_exp;         // Transfers the target should allow
		int        first_devsel;
		int        first_trdy;
		int        wait_end;
		logic      claimed;
		logic      is_wr;
		logic      cur_irdy;
		logic      cur_frame;
		logic      last_given;    // Stop seen in a wait state
		logic      finish_next;
		logic      done;
		word_idx_t w;
		data_t     wd;
		claimed = claims(row);
		is_wr   = (row.cmd == WR);
		n_exp   = claimed ? int'(row.phases) : 0;
		for (int i = 0; claimed && i < int'(row.phases) && n_exp == int'(row.phases); i++)
		begin
			if (stop_at(row, i))
				n_exp = i + 1;
		end
		@(posedge clk);
		frame  <= 1'b0;                                      // Address phase
		irdy   <= 1'b1;
		ad_in  <= row.addr;
		cbe_in <= row.cmd;
		@(posedge clk);
		k            = 0;
		t            = 0;
		first_devsel = -1;
		first_trdy   = -1;
		last_given   = 1'b0;
		finish_next  = 1'b0;
		done         = 1'b0;
		while (!done)
		begin
			if (finish_next || (!claimed && t >= 4))     // Normal end or master abort
			begin
				frame  <= 1'b1;
				irdy   <= 1'b1;
				ad_in  <= '0;
				cbe_in <= '0;
				done = 1'b1;
			end
			else
			begin
				cur_irdy  = claimed && !last_given && (($random(seed) & 32'h3) == 0);
				cur_frame = !cur_irdy && (last_given || k == int'(row.phases) - 1);
				w         = word_at(row, k);
				wd        = write_data(row, k, w);
				frame  <= cur_frame;
				irdy   <= cur_irdy;
				ad_in  <= is_wr ? wd : '0;
				cbe_in <= row.be;
				@(negedge clk);                              // Outputs settled for the next edge
				if (!devsel && first_devsel < 0)
					first_devsel = t;
				if (!trdy && first_trdy < 0)
					first_trdy = t;
				if (!claimed)
					check("devsel on unclaimed access", data_t'(devsel), 32'd1);
				if (!cur_irdy && !trdy)                      // Transfer on the coming edge
				begin
					check("stop on transfer", data_t'(stop), stop_at(row, k) ? 32'd0 : 32'd1);
					if (is_wr)
					begin
						for (int b = 0; b < 4; b++)
						begin
							if (!row.be[b])
								ref_mem[w][b*8 +: 8] = wd[b*8 +: 8];
						end
					end
					else
					begin
						check("ad_oe on read", data_t'(ad_oe), 32'd1);
						check("read data", ad_out, ref_mem[w]);
					end
					k++;
					if (cur_frame || !stop)
						finish_next = 1'b1;
				end
				else if (!trdy && !stop)
					last_given = 1'b1;                       // Disconnect during a wait state
				t++;
				@(posedge clk);
			end
		end
		wait_end = 0;
		@(negedge clk);
		while (devsel !== 1'b1 && wait_end < 3)
		begin
			@(negedge clk);
			wait_end++;
		end
		check("devsel after end", data_t'(devsel), 32'd1);
		check("trdy after end", data_t'(trdy), 32'd1);
		check("stop after end", data_t'(stop), 32'd1);
		check("ad_oe after end", data_t'(ad_oe), 32'd0);
		check("transfer count", data_t'(k), data_t'(n_exp));
		if (claimed)
		begin
			check("devsel delay", data_t'(first_devsel), 32'd1);
			check("trdy delay", data_t'(first_trdy), is_wr ? 32'd1 : 32'd2);
		end
		else
			check("trdy on unclaimed access", data_t'(first_trdy), 32'hFFFF_FFFF);
	endtask

	////////////////////////////////////////////////////////////
	// Stimulus table and run
	////////////////////////////////////////////////////////////

	initial
	begin
		clk    = 1'b0;
		rst    = 1'b0;
		frame  = 1'b1;
		irdy   = 1'b1;
		ad_in  = '0;
		cbe_in = '0;
		errors = 0;
		checks = 0;
		cycles = 0;
		seed   = 32'h7143;
		// cmd, addr, phases, be, seed, fill
		rows[0]  = '{WR, waddr(0, LIN), 8'd64, 4'h0, 32'h0, 1'b1};           // Whole window
		rows[1]  = '{WR, waddr(16, LIN), 8'd6, 4'h0, 32'h1234_5678, 1'b0};
		rows[2]  = '{RM, waddr(16, LIN), 8'd6, 4'h0, 32'h0, 1'b0};
		rows[3]  = '{WR, waddr(18, LIN), 8'd3, 4'b1010, 32'hCAFE_0000, 1'b0};  // Lanes 0 and 2
		rows[4]  = '{RM, waddr(16, LIN), 8'd6, 4'h0, 32'h0, 1'b0};
		rows[5]  = '{RD, waddr(20, LIN), 8'd5, 4'h0, 32'h0, 1'b0};
		rows[6]  = '{RL, waddr(8, LIN), 8'd6, 4'h0, 32'h0, 1'b0};
		rows[7]  = '{RL, waddr(10, WRAP), 8'd4, 4'h0, 32'h0, 1'b0};          // 10 11 8 9
		rows[8]  = '{WR, waddr(61, LIN), 8'd6, 4'h0, 32'h0BAD_F00D, 1'b0};   // Window end
		rows[9]  = '{RM, waddr(59, LIN), 8'd8, 4'h0, 32'h0, 1'b0};
		rows[10] = '{4'b0011, waddr(16, LIN), 8'd3, 4'h0, 32'hDEAD_0000, 1'b0};  // I/O write
		rows[11] = '{RM, waddr(16, 2'b01), 8'd3, 4'h0, 32'h0, 1'b0};         // Reserved order
		rows[12] = '{WR, BASE + 32'h100, 8'd3, 4'h0, 32'h5555_0000, 1'b0};
		rows[13] = '{RM, 32'h0000_0FF0, 8'd3, 4'h0, 32'h0, 1'b0};
		rows[14] = '{RM, waddr(16, LIN), 8'd6, 4'h0, 32'h0, 1'b0};
		rows[15] = '{WR, waddr(13, WRAP), 8'd4, 4'b0011, 32'h7777_0000, 1'b0};
		rows[16] = '{RL, waddr(12, LIN), 8'd4, 4'h0, 32'h0, 1'b0};
		rows[17] = '{RD, waddr(0, LIN), 8'd1, 4'h0, 32'h0, 1'b0};
		rows[18] = '{RM, waddr(40, WRAP), 8'd7, 4'h0, 32'h0, 1'b0};
		rows[19] = '{RL, waddr(62, LIN), 8'd4, 4'h0, 32'h0, 1'b0};           // End before line
		repeat (10) @(posedge clk);
		rst <= 1'b1;
		@(negedge clk);
		check("devsel after reset", data_t'(devsel), 32'd1);
		check("trdy after reset", data_t'(trdy), 32'd1);
		check("stop after reset", data_t'(stop), 32'd1);
		check("ad_oe after reset", data_t'(ad_oe), 32'd0);
		for (int r = 0; r < NUM_ROWS; r++)
		begin
			run_row(rows[r]);
			repeat (2) @(posedge clk);                       // Idle gap
		end
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== pci_target.f ====
verilog/pci_target_pkg.sv
verilog/target_ram.sv
verilog/burst_addr_gen.sv
verilog/target_fsm.sv
verilog/pci_target_top.sv
test/pci_target_props.sv
test/pci_target_tb.sv

// ==== Makefile ====
TOP := pci_target_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f pci_target.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f pci_target.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TEST RESULT: PASS"

clean:
	rm -rf obj_dir
